//--- common/icache_pkg.sv
// shared instruction cache definitions
// fetch address split, geometry constants, line type
// refill FSM state encoding
`default_nettype none

package icache_pkg;

    // geometry, fixed by the address split below
    localparam int NUM_BANKS      = 4;
    localparam int LINES_PER_BANK = 8;

    // 32-bit fetch address
    typedef logic [31:0]  addr_t;
    // address bits 31..9
    typedef logic [22:0]  tag_t;
    // address bits 8..4
    typedef logic [4:0]   index_t;
    // index bits 4..3
    typedef logic [1:0]   bank_sel_t;
    // index bits 2..0
    typedef logic [2:0]   line_sel_t;
    // one 16-byte line
    typedef logic [127:0] line_t;

    // refill FSM of the lookup
    typedef enum logic [1:0] {
        IDLE,
        REFILL_REQ,
        REFILL_WAIT
    } lookup_state_e;

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[31:9];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[8:4];
    endfunction

    function automatic bank_sel_t index_bank(input index_t idx);
        return idx[4:3];
    endfunction

    function automatic line_sel_t index_line(input index_t idx);
        return idx[2:0];
    endfunction

    // byte offset forced to zero
    function automatic addr_t line_addr(input addr_t addr);
        return {addr[31:4], 4'b0000};
    endfunction

endpackage

`default_nettype wire

//--- icache_bank/icache_bank.sv
// one instruction cache bank of eight lines
// tag, data and valid arrays, asynchronous read
// synchronous write, flush of all valid bits
`timescale 1ns/10ps
`default_nettype none

module icache_bank (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   flush,
    input  icache_pkg::line_sel_t rd_line,
    input  wire                   wr_en,
    input  icache_pkg::line_sel_t wr_line,
    input  icache_pkg::tag_t      wr_tag,
    input  icache_pkg::line_t     wr_data,
    output icache_pkg::tag_t      rd_tag,
    output logic                  rd_valid,
    output icache_pkg::line_t     rd_data
);
    import icache_pkg::*;

    // tag and data arrays hold no reset
    tag_t  tag_mem  [LINES_PER_BANK];
    line_t data_mem [LINES_PER_BANK];

    // one valid bit per line
    logic [LINES_PER_BANK-1:0] valid_q;
    logic [LINES_PER_BANK-1:0] valid_d;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_line]  <= wr_tag;
            data_mem[wr_line] <= wr_data;
        end
    end

    // flush clears everything first
    // a fill in the same cycle sets its own bit back
    always_comb begin
        valid_d = valid_q;
        if (flush) begin
            valid_d = '0;
        end
        if (wr_en) begin
            valid_d[wr_line] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // flop array read, no clock involved
    assign rd_tag   = tag_mem[rd_line];
    assign rd_valid = valid_q[rd_line];
    assign rd_data  = data_mem[rd_line];

endmodule

`default_nettype wire

//--- logic/icache_req_queue.sv
// fetch request FIFO with credit return
// issue register feeding the lookup and the bank read line
`timescale 1ns/10ps
`default_nettype none

module icache_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   req_valid,
    input  icache_pkg::addr_t     req_addr,
    input  wire                   issue_accept,
    output logic                  req_credit,
    output logic                  issue_valid,
    output icache_pkg::addr_t     issue_addr,
    output icache_pkg::line_sel_t rd_line
);
    import icache_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

    // address storage, payload only
    addr_t fifo_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // full cannot happen while the fetch side respects its credits
    assign push = req_valid && (count != FULL_CNT);

    // head moves up when the issue slot frees or is empty
    assign pop = (count != '0) && (issue_accept || !issue_valid);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= req_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // depth need not be a power of two
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // issue register control, one credit back per entry moved
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
            req_credit  <= 1'b0;
        end else begin
            req_credit <= pop;
            if (pop) begin
                issue_valid <= 1'b1;
            end else if (issue_accept) begin
                issue_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_addr <= fifo_mem[rd_ptr];
        end
    end

    // same line of every bank is read, lookup picks the bank
    assign rd_line = index_line(addr_index(issue_addr));

endmodule

`default_nettype wire

//--- logic/icache_lookup.sv
// instruction cache lookup
// bank select, tag compare, hit response register
// refill FSM with memory credit counter
`timescale 1ns/10ps
`default_nettype none

module icache_lookup #(
    parameter int MEM_CREDITS = 1
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              issue_valid,
    input  icache_pkg::addr_t                issue_addr,
    input  icache_pkg::tag_t                 bank_tag [icache_pkg::NUM_BANKS],
    input  wire  [icache_pkg::NUM_BANKS-1:0] bank_valid,
    input  icache_pkg::line_t                bank_data [icache_pkg::NUM_BANKS],
    input  wire                              mem_credit,
    input  wire                              mem_fill_valid,
    input  icache_pkg::line_t                mem_fill_data,
    output logic                             issue_accept,
    output logic [icache_pkg::NUM_BANKS-1:0] wr_en,
    output icache_pkg::line_sel_t            wr_line,
    output icache_pkg::tag_t                 wr_tag,
    output icache_pkg::line_t                wr_data,
    output logic                             resp_valid,
    output logic                             resp_hit,
    output icache_pkg::line_t                resp_data,
    output logic                             mem_req_valid,
    output icache_pkg::addr_t                mem_req_addr
);
    import icache_pkg::*;

    localparam int CRD_W = $clog2(MEM_CREDITS + 1);

    lookup_state_e state_q;
    lookup_state_e state_d;

    logic [CRD_W-1:0] mem_crd_q;

    // fields of the issued address
    index_t    req_index;
    tag_t      req_tag;
    bank_sel_t req_bank;

    tag_t  sel_tag;
    logic  sel_valid;
    line_t sel_data;
    logic  hit;

    logic hit_accept;
    logic fill_write;

    assign req_index = addr_index(issue_addr);
    assign req_tag   = addr_tag(issue_addr);
    assign req_bank  = index_bank(req_index);

    // all banks read the same line, take the one addressed
    assign sel_tag   = bank_tag[req_bank];
    assign sel_valid = bank_valid[req_bank];
    assign sel_data  = bank_data[req_bank];
    assign hit       = sel_valid && (sel_tag == req_tag);

    assign hit_accept = (state_q == IDLE) && issue_valid && hit;
    assign fill_write = (state_q == REFILL_WAIT) && mem_fill_valid;

    // retire on a hit or on the fill
    assign issue_accept = hit_accept || fill_write;

    // request goes out as soon as a credit is held
    assign mem_req_valid = (state_q == REFILL_REQ) && (mem_crd_q != '0);
    assign mem_req_addr  = line_addr(issue_addr);

    // fill write into the bank of the missed line
    always_comb begin
        wr_en           = '0;
        wr_en[req_bank] = fill_write;
    end

    assign wr_line = index_line(req_index);
    assign wr_tag  = req_tag;
    assign wr_data = mem_fill_data;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (issue_valid && !hit) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                // stalls here while memory holds all credits
                if (mem_req_valid) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_fill_valid) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // spend one per request, memory hands one back per pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_crd_q <= CRD_W'(MEM_CREDITS);
        end else begin
            case ({mem_req_valid, mem_credit})
                2'b10:   mem_crd_q <= mem_crd_q - 1'b1;
                2'b01:   mem_crd_q <= mem_crd_q + 1'b1;
                default: mem_crd_q <= mem_crd_q;
            endcase
        end
    end

    // response flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
        end else begin
            resp_valid <= issue_accept;
            resp_hit   <= hit_accept;
        end
    end

    // response payload, bank data on a hit or fill data
    always_ff @(posedge clk) begin
        if (hit_accept) begin
            resp_data <= sel_data;
        end else if (fill_write) begin
            resp_data <= mem_fill_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_top.sv
// instruction cache top level
// request queue, four line banks, lookup and refill control
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_CREDITS = 1
) (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               req_valid,
    input  icache_pkg::addr_t req_addr,
    input  wire               flush,
    input  wire               mem_credit,
    input  wire               mem_fill_valid,
    input  icache_pkg::line_t mem_fill_data,
    output logic              req_credit,
    output logic              resp_valid,
    output logic              resp_hit,
    output icache_pkg::line_t resp_data,
    output logic              mem_req_valid,
    output icache_pkg::addr_t mem_req_addr
);
    import icache_pkg::*;

    // queue to lookup
    logic      issue_valid;
    addr_t     issue_addr;
    logic      issue_accept;
    line_sel_t rd_line;

    // lookup to banks
    logic [NUM_BANKS-1:0] wr_en;
    line_sel_t            wr_line;
    tag_t                 wr_tag;
    line_t                wr_data;

    // banks to lookup
    wire tag_t            bank_tag  [NUM_BANKS];
    wire [NUM_BANKS-1:0]  bank_valid;
    wire line_t           bank_data [NUM_BANKS];

    icache_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_req_queue (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .issue_accept (issue_accept),
        .req_credit   (req_credit),
        .issue_valid  (issue_valid),
        .issue_addr   (issue_addr),
        .rd_line      (rd_line)
    );

    // one bank per value of the two high index bits
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        icache_bank u_bank (
            .clk      (clk),
            .arst_n   (arst_n),
            .flush    (flush),
            .rd_line  (rd_line),
            .wr_en    (wr_en[b]),
            .wr_line  (wr_line),
            .wr_tag   (wr_tag),
            .wr_data  (wr_data),
            .rd_tag   (bank_tag[b]),
            .rd_valid (bank_valid[b]),
            .rd_data  (bank_data[b])
        );
    end

    icache_lookup #(
        .MEM_CREDITS (MEM_CREDITS)
    ) u_lookup (
        .clk            (clk),
        .arst_n         (arst_n),
        .issue_valid    (issue_valid),
        .issue_addr     (issue_addr),
        .bank_tag       (bank_tag),
        .bank_valid     (bank_valid),
        .bank_data      (bank_data),
        .mem_credit     (mem_credit),
        .mem_fill_valid (mem_fill_valid),
        .mem_fill_data  (mem_fill_data),
        .issue_accept   (issue_accept),
        .wr_en          (wr_en),
        .wr_line        (wr_line),
        .wr_tag         (wr_tag),
        .wr_data        (wr_data),
        .resp_valid     (resp_valid),
        .resp_hit       (resp_hit),
        .resp_data      (resp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr)
    );

endmodule

`default_nettype wire

//--- tests/tb_icache.sv
// testbench for the instruction cache top level
// file driven fetch stimulus, in-order response scoreboard
// memory model with random fill delay, credit tracking
`timescale 1ns/10ps
`default_nettype none

module tb_icache;

    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_CREDITS = 1;
    localparam int WAIT_LIMIT  = 200;

    logic         clk;
    logic         arst_n;
    logic         req_valid;
    logic [31:0]  req_addr;
    logic         flush;
    logic         mem_credit;
    logic         mem_fill_valid;
    logic [127:0] mem_fill_data;

    wire          req_credit;
    wire          resp_valid;
    wire          resp_hit;
    wire  [127:0] resp_data;
    wire          mem_req_valid;
    wire  [31:0]  mem_req_addr;

    // stimulus from the data file
    int          op_q [$];
    logic [31:0] addr_q [$];
    int          hit_q [$];

    // expected responses in request order
    logic [31:0] exp_addr_q [$];
    bit          exp_hit_q [$];
    // line addresses expected on the memory side
    logic [31:0] miss_q [$];

    // refills waiting in the memory model
    logic [31:0] pend_addr [$];
    int          pend_delay [$];

    int credits;
    int reads_sent;
    int misses_sent;
    int credit_pulses;
    int mem_reqs;
    int checks;
    int value_errs;
    int other_errs;
    bit timed_out;

    logic [31:0] lcg_state = 32'h7936_712d;

    icache_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MEM_CREDITS (MEM_CREDITS)
    ) u_dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .flush          (flush),
        .mem_credit     (mem_credit),
        .mem_fill_valid (mem_fill_valid),
        .mem_fill_data  (mem_fill_data),
        .req_credit     (req_credit),
        .resp_valid     (resp_valid),
        .resp_hit       (resp_hit),
        .resp_data      (resp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word k holds its own byte address xor a fixed pattern
    function automatic logic [127:0] fill_line(input logic [31:0] base);
        logic [127:0] line;
        int k;
        for (k = 0; k < 4; k++) begin
            line[32*k +: 32] = (base + 32'(4 * k)) ^ 32'ha5a5_0000;
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic load_stimulus();
        integer fd;
        integer c;
        integer r;
        integer hc;
        logic [31:0] a;
        fd = $fopen("tests/icache_input.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the stimulus file");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    // comment runs to end of line
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (c == "R" || c == "F") begin
                    r = $fscanf(fd, "%h %c", a, hc);
                    if (r != 2) begin
                        other_errs++;
                        $display("malformed line in the stimulus file");
                    end else begin
                        op_q.push_back(c);
                        addr_q.push_back(a);
                        hit_q.push_back(hc);
                    end
                end
                if (c != -1) begin
                    c = $fgetc(fd);
                end
            end
            $fclose(fd);
        end
        if (op_q.size() == 0) begin
            other_errs++;
            $display("stimulus file holds no operations");
        end
    endtask

    // only while a fetch credit is held
    task automatic send_read(input logic [31:0] addr, input int hit_ch);
        int n;
        n = 0;
        while (credits == 0 && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= WAIT_LIMIT) begin
                other_errs++;
                timed_out = 1'b1;
                $display("timeout at %0t ns waiting for a fetch credit", $time);
            end
        end
        if (!timed_out) begin
            req_valid = 1'b1;
            req_addr  = addr;
            credits--;
            reads_sent++;
            exp_addr_q.push_back(addr);
            exp_hit_q.push_back(hit_ch == "1");
            if (hit_ch != "1") begin
                misses_sent++;
                miss_q.push_back({addr[31:4], 4'h0});
            end
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic drain_responses();
        int n;
        n = 0;
        while (exp_addr_q.size() != 0 && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= WAIT_LIMIT) begin
                other_errs++;
                timed_out = 1'b1;
                $display("timeout at %0t ns, %0d responses never arrived",
                         $time, exp_addr_q.size());
            end
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // memory model answers each request once after 1 to 8 cycles
    always @(posedge clk) begin
        #1;
        mem_fill_valid = 1'b0;
        mem_credit     = 1'b0;
        if (pend_addr.size() != 0) begin
            if (pend_delay[0] <= 1) begin
                // credit goes back with the fill
                mem_fill_valid = 1'b1;
                mem_credit     = 1'b1;
                mem_fill_data  = fill_line(pend_addr[0]);
                void'(pend_addr.pop_front());
                void'(pend_delay.pop_front());
            end else begin
                pend_delay[0] = pend_delay[0] - 1;
            end
        end
    end

    // monitors sample mid cycle
    always @(negedge clk) begin
        logic [31:0] a;
        logic [31:0] rnd;
        bit          h;
        if (req_credit) begin
            credit_pulses++;
            credits++;
            if (credits > QUEUE_DEPTH) begin
                other_errs++;
                $display("more fetch credits returned than the queue holds at %0t ns", $time);
            end
        end
        if (mem_req_valid) begin
            mem_reqs++;
            if (pend_addr.size() >= MEM_CREDITS) begin
                other_errs++;
                $display("memory request at %0t ns with no memory credit left", $time);
            end
            if (miss_q.size() == 0) begin
                other_errs++;
                $display("memory request at %0t ns with no miss expected", $time);
            end else begin
                a = miss_q.pop_front();
                check_value("mem_req_addr", a, mem_req_addr);
            end
            rnd = next_rand();
            pend_addr.push_back(mem_req_addr);
            pend_delay.push_back(1 + int'(rnd[18:16]));
        end
        if (resp_valid) begin
            if (exp_addr_q.size() == 0) begin
                other_errs++;
                $display("response at %0t ns with no read outstanding", $time);
            end else begin
                a = exp_addr_q.pop_front();
                h = exp_hit_q.pop_front();
                check_value("resp_hit", h, resp_hit);
                check_value("resp_data", fill_line({a[31:4], 4'h0}), resp_data);
            end
        end
    end

    initial begin
        int i;
        clk            = 1'b0;
        arst_n         = 1'b0;
        req_valid      = 1'b0;
        req_addr       = '0;
        flush          = 1'b0;
        mem_credit     = 1'b0;
        mem_fill_valid = 1'b0;
        mem_fill_data  = '0;
        credits        = QUEUE_DEPTH;
        timed_out      = 1'b0;
        load_stimulus();

        // outputs quiet through reset
        repeat (8) begin
            @(posedge clk);
            #1;
            check_value("resp_valid", 1'b0, resp_valid);
            check_value("mem_req_valid", 1'b0, mem_req_valid);
            check_value("req_credit", 1'b0, req_credit);
        end
        arst_n = 1'b1;
        // and for a few idle cycles after it
        repeat (3) begin
            @(negedge clk);
            check_value("resp_valid", 1'b0, resp_valid);
            check_value("mem_req_valid", 1'b0, mem_req_valid);
            check_value("req_credit", 1'b0, req_credit);
        end
        @(posedge clk);
        #1;

        for (i = 0; i < op_q.size() && !timed_out; i++) begin
            if (op_q[i] == "F") begin
                // no read in flight across a flush
                drain_responses();
                if (!timed_out) begin
                    pulse_flush();
                end
            end else begin
                send_read(addr_q[i], hit_q[i]);
            end
        end
        drain_responses();

        // idle tail catches stray requests or responses
        repeat (10) @(posedge clk);
        #1;
        check_value("req_credit pulses", reads_sent, credit_pulses);
        check_value("mem_req_valid count", misses_sent, mem_reqs);
        check_value("fetch credits held", QUEUE_DEPTH, credits);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (timed_out || value_errs != 0 || other_errs != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/icache_input.txt
# columns: op (R read, F flush), fetch address in hex, expected hit (0, 1, - for a flush)
# expected hits follow the direct-mapped rule, 5-bit index from address bits 8..4
# cold miss, then hits in the same line
R 00001000 0
R 00001004 1
R 0000100c 1
# conflict eviction on index 0
R 00003000 0
R 00001008 0
R 00003004 0
R 00003000 1
# one line in each bank, then hits
R 00000010 0
R 00000090 0
R 00000110 0
R 00000190 0
R 00000014 1
R 00000094 1
R 00000118 1
R 0000019c 1
# top of the address space, index 31
R fffffff0 0
R 7ffffff4 0
R fffffffc 0
R fffffff8 1
# flush, then refetch
F 00000000 -
R 00000094 0
R 00003000 0
R 00000094 1
R fffffff0 0
# back to back mix of hits and misses
R 00000210 0
R 00000290 0
R 00000010 0
R 00000214 0
R 00000090 0
R 00000298 0
R 0000029c 1
R 00000218 1
R 00003008 1
R 00000110 0
R 00000114 1
# second flush with nothing outstanding
F 00000000 -
R 00000114 0
R fffffff4 0
R fffffff4 1

//--- project.f
common/icache_pkg.sv
icache_bank/icache_bank.sv
logic/icache_req_queue.sv
logic/icache_lookup.sv
logic/icache_top.sv
tests/tb_icache.sv
